// ==== fftPkg.sv ====
package fftPkg;

    parameter int sampleWidth = 16;
    parameter int fftSize = 8;
    parameter int stageCount = 3;
    parameter int indexWidth = 3;
    parameter int fifoDepth = 16;
    parameter int countWidth = 5;
    parameter int addrWidth = 8;
    parameter int twiddleShift = 14;

    // One data word, raw on the bus, split into re and im in the datapath
    typedef union packed {
        logic [2*sampleWidth-1:0] raw;
        struct packed {
            logic signed [sampleWidth-1:0] re;
            logic signed [sampleWidth-1:0] im;
        } part;
    } sampleWord;

    // Register byte offsets
    parameter logic [addrWidth-1:0] regCtrl = 8'h00;
    parameter logic [addrWidth-1:0] regStatus = 8'h04;
    parameter logic [addrWidth-1:0] regDataIn = 8'h08;
    parameter logic [addrWidth-1:0] regDataOut = 8'h0C;
    parameter logic [addrWidth-1:0] regLevels = 8'h10;

    parameter logic [1:0] respOkay = 2'b00;
    parameter logic [1:0] respSlvErr = 2'b10;

    // Sequencer phases
    parameter logic [1:0] phaseIdle = 2'd0;
    parameter logic [1:0] phaseLoad = 2'd1;
    parameter logic [1:0] phaseCalc = 2'd2;
    parameter logic [1:0] phaseUnload = 2'd3;

    // Forward twiddles W8^k in Q1.14
    parameter logic signed [sampleWidth-1:0] twiddleRe [4] =
        '{16'sd16384, 16'sd11585, 16'sd0, -16'sd11585};
    parameter logic signed [sampleWidth-1:0] twiddleIm [4] =
        '{16'sd0, -16'sd11585, -16'sd16384, -16'sd11585};

endpackage

// ==== fftAxiRegs.sv ====
`timescale 1ns/1ps

module fftAxiRegs (
    input  logic clk,
    input  logic rst,
    input  logic [fftPkg::addrWidth-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [31:0] wdata,
    input  logic [3:0] wstrb,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [fftPkg::addrWidth-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [31:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready,
    output logic startFwd,
    output logic startInv,
    output logic inPush,
    output logic [31:0] inData,
    input  logic inFull,
    input  logic [fftPkg::countWidth-1:0] inCount,
    output logic outPop,
    input  logic [31:0] outData,
    input  logic outEmpty,
    input  logic [fftPkg::countWidth-1:0] outCount,
    input  logic calculating,
    input  logic done,
    input  logic isInverse
);

    logic writeAccept;
    logic readAccept;
    logic ctrlWrite;
    logic dataInWrite;
    logic [31:0] readWord;
    logic [1:0] readResp;

    ////////////////////////////////////////////////////////////////////////////
    // Write channel

    assign writeAccept = awvalid && wvalid && !bvalid;
    assign awready = writeAccept;
    assign wready = writeAccept;

    assign ctrlWrite = writeAccept && (awaddr == fftPkg::regCtrl) && wstrb[0];
    assign dataInWrite = writeAccept && (awaddr == fftPkg::regDataIn);

    // Bit 0 wins over bit 1
    assign startFwd = ctrlWrite && wdata[0];
    assign startInv = ctrlWrite && wdata[1] && !wdata[0];

    assign inPush = dataInWrite && !inFull;
    assign inData = wdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (writeAccept) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (writeAccept) begin
            bresp <= (dataInWrite && inFull) ? fftPkg::respSlvErr : fftPkg::respOkay;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read channel

    assign arready = !rvalid;
    assign readAccept = arvalid && arready;
    assign outPop = readAccept && (araddr == fftPkg::regDataOut) && !outEmpty;

    always_comb begin
        readWord = '0;
        readResp = fftPkg::respOkay;
        case (araddr)
            fftPkg::regStatus: readWord = {29'd0, isInverse, done, calculating};
            fftPkg::regLevels: begin
                readWord[fftPkg::countWidth-1:0] = inCount;
                readWord[16 +: fftPkg::countWidth] = outCount;
            end
            fftPkg::regDataOut: begin
                readWord = outData;
                if (outEmpty) begin
                    readWord = '0;
                    readResp = fftPkg::respSlvErr;
                end
            end
            default: readWord = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (readAccept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Captured at the address cycle
    always_ff @(posedge clk) begin
        if (readAccept) begin
            rdata <= readWord;
            rresp <= readResp;
        end
    end

endmodule

// ==== sampleFifo.sv ====
`timescale 1ns/1ps

module sampleFifo #(
    parameter int depth = fftPkg::fifoDepth
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic [31:0] pushData,
    input  logic pop,
    output logic [31:0] popData,
    output logic full,
    output logic empty,
    output logic [fftPkg::countWidth-1:0] count
);

    localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;

    logic [31:0] mem [depth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic doPush;
    logic doPop;

    assign full = (count == fftPkg::countWidth'(depth));
    assign empty = (count == '0);
    assign doPop = pop && !empty;
    // A full FIFO still takes a word when one leaves in the same cycle
    assign doPush = push && (!full || doPop);

    // First word falls through
    assign popData = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== fftControl.sv ====
`timescale 1ns/1ps

module fftControl (
    input  logic clk,
    input  logic rst,
    input  logic startFwd,
    input  logic startInv,
    input  logic inEmpty,
    input  logic outFull,
    input  logic lastItem,
    output logic calculating,
    output logic loadStep,
    output logic calcStep,
    output logic unloadStep,
    output logic isInverse,
    output logic done,
    output logic [1:0] phase
);

    localparam logic [2:0] stIdle = 3'd0;
    localparam logic [2:0] stLoad = 3'd1;
    localparam logic [2:0] stCalc = 3'd2;
    localparam logic [2:0] stUnload = 3'd3;
    localparam logic [2:0] stDone = 3'd4;

    logic [2:0] state;
    logic [2:0] nextState;
    logic start;

    assign start = (state == stIdle) && (startFwd || startInv);
    assign calculating = (state != stIdle);

    always_comb begin
        nextState = state;
        loadStep = 1'b0;
        calcStep = 1'b0;
        unloadStep = 1'b0;
        phase = fftPkg::phaseIdle;
        case (state)
            stIdle: begin
                if (start) nextState = stLoad;
            end
            // Wait on an empty input FIFO
            stLoad: begin
                phase = fftPkg::phaseLoad;
                loadStep = !inEmpty;
                if (loadStep && lastItem) nextState = stCalc;
            end
            stCalc: begin
                phase = fftPkg::phaseCalc;
                calcStep = 1'b1;
                if (lastItem) nextState = stUnload;
            end
            // Stalls while the output FIFO is full
            stUnload: begin
                phase = fftPkg::phaseUnload;
                unloadStep = !outFull;
                if (unloadStep && lastItem) nextState = stDone;
            end
            stDone: nextState = stIdle;
            default: nextState = stIdle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= stIdle;
            isInverse <= 1'b0;
            done <= 1'b0;
        end else begin
            state <= nextState;
            if (start) begin
                isInverse <= !startFwd;
                done <= 1'b0;
            end else if (state == stDone) begin
                done <= 1'b1;
            end
        end
    end

endmodule

// ==== fftSequencer.sv ====
`timescale 1ns/1ps

module fftSequencer (
    input  logic clk,
    input  logic rst,
    input  logic [1:0] phase,
    input  logic loadStep,
    input  logic calcStep,
    input  logic unloadStep,
    output logic [fftPkg::indexWidth-1:0] index,
    output logic [1:0] stage,
    output logic [1:0] twiddleIndex,
    output logic [fftPkg::indexWidth-1:0] addrA,
    output logic [fftPkg::indexWidth-1:0] addrB,
    output logic lastItem
);

    localparam logic [3:0] lastCalc = 4'(fftPkg::stageCount * fftPkg::fftSize / 2 - 1);
    localparam logic [3:0] lastMove = 4'(fftPkg::fftSize - 1);

    logic [3:0] count;
    logic [1:0] phaseQ;
    logic step;
    logic inCalc;
    logic [2:0] butterfly;
    logic [2:0] halfSpan;
    logic [2:0] offset;
    logic [2:0] groupBase;
    logic [2:0] calcA;
    logic [3:0] twiddleWide;
    logic [fftPkg::indexWidth-1:0] revIndex;

    assign step = loadStep | calcStep | unloadStep;
    assign inCalc = (phase == fftPkg::phaseCalc);
    assign index = count[fftPkg::indexWidth-1:0];
    assign lastItem = inCalc ? (count == lastCalc) : (count == lastMove);

    // Four butterflies per stage
    assign stage = inCalc ? count[3:2] : 2'd0;
    assign butterfly = {1'b0, count[1:0]};
    assign halfSpan = 3'd1 << stage;
    assign offset = butterfly & (halfSpan - 3'd1);
    assign groupBase = (butterfly >> stage) << (stage + 2'd1);
    assign calcA = groupBase + offset;
    assign twiddleWide = {offset[1:0], 2'b00} >> stage;
    assign twiddleIndex = twiddleWide[1:0];

    always_comb begin
        for (int i = 0; i < fftPkg::indexWidth; i++) begin
            revIndex[i] = index[fftPkg::indexWidth-1-i];
        end
    end

    always_comb begin
        if (inCalc) begin
            addrA = calcA;
        end else if (phase == fftPkg::phaseLoad) begin
            addrA = revIndex;
        end else begin
            addrA = index;
        end
    end

    assign addrB = calcA + halfSpan;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
            phaseQ <= fftPkg::phaseIdle;
        end else begin
            phaseQ <= phase;
            if (step) begin
                count <= lastItem ? 4'd0 : count + 4'd1;
            end else if (phase != phaseQ) begin
                count <= '0;
            end
        end
    end

endmodule

// ==== fftDatapath.sv ====
`timescale 1ns/1ps

module fftDatapath (
    input  logic clk,
    input  logic rst,
    input  logic loadStep,
    input  logic calcStep,
    input  logic isInverse,
    input  logic [fftPkg::indexWidth-1:0] addrA,
    input  logic [fftPkg::indexWidth-1:0] addrB,
    input  logic [1:0] twiddleIndex,
    input  fftPkg::sampleWord loadData,
    output fftPkg::sampleWord readData
);

    localparam int sw = fftPkg::sampleWidth;

    fftPkg::sampleWord regFile [fftPkg::fftSize];
    fftPkg::sampleWord wordA;
    fftPkg::sampleWord wordB;
    fftPkg::sampleWord sumWord;
    fftPkg::sampleWord diffWord;

    logic signed [sw-1:0] wRe;
    logic signed [sw-1:0] wIm;
    logic signed [31:0] prodRR;
    logic signed [31:0] prodII;
    logic signed [31:0] prodRI;
    logic signed [31:0] prodIR;
    logic signed [31:0] tRe;
    logic signed [31:0] tIm;
    logic signed [31:0] sumRe;
    logic signed [31:0] sumIm;
    logic signed [31:0] diffRe;
    logic signed [31:0] diffIm;

    assign wordA = regFile[addrA];
    assign wordB = regFile[addrB];
    assign readData = wordA;

    ////////////////////////////////////////////////////////////////////////////
    // Butterfly

    // Inverse uses the conjugate twiddle
    assign wRe = fftPkg::twiddleRe[twiddleIndex];
    assign wIm = isInverse ? -fftPkg::twiddleIm[twiddleIndex] : fftPkg::twiddleIm[twiddleIndex];

    assign prodRR = wordB.part.re * wRe;
    assign prodII = wordB.part.im * wIm;
    assign prodRI = wordB.part.re * wIm;
    assign prodIR = wordB.part.im * wRe;

    // Each product truncated back to Q0 before the sum
    assign tRe = (prodRR >>> fftPkg::twiddleShift) - (prodII >>> fftPkg::twiddleShift);
    assign tIm = (prodRI >>> fftPkg::twiddleShift) + (prodIR >>> fftPkg::twiddleShift);

    assign sumRe = wordA.part.re + tRe;
    assign sumIm = wordA.part.im + tIm;
    assign diffRe = wordA.part.re - tRe;
    assign diffIm = wordA.part.im - tIm;

    // Halve with truncation toward minus infinity
    assign sumWord.part.re = sumRe[sw:1];
    assign sumWord.part.im = sumIm[sw:1];
    assign diffWord.part.re = diffRe[sw:1];
    assign diffWord.part.im = diffIm[sw:1];

    ////////////////////////////////////////////////////////////////////////////
    // Register file

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < fftPkg::fftSize; i++) begin
                regFile[i] <= '0;
            end
        end else if (loadStep) begin
            regFile[addrA] <= loadData;
        end else if (calcStep) begin
            regFile[addrA] <= sumWord;
            regFile[addrB] <= diffWord;
        end
    end

endmodule

// ==== fftTop.sv ====
`timescale 1ns/1ps

module fftTop #(
    parameter int fifoDepth = fftPkg::fifoDepth
) (
    input  logic clk,
    input  logic rst,
    input  logic [fftPkg::addrWidth-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [31:0] wdata,
    input  logic [3:0] wstrb,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [fftPkg::addrWidth-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [31:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready
);

    logic startFwd;
    logic startInv;
    logic inPush;
    logic [31:0] inData;
    logic inFull;
    logic inEmpty;
    logic [fftPkg::countWidth-1:0] inCount;
    logic [31:0] inPopData;
    logic outPop;
    logic [31:0] outData;
    logic outFull;
    logic outEmpty;
    logic [fftPkg::countWidth-1:0] outCount;
    logic calculating;
    logic done;
    logic isInverse;
    logic loadStep;
    logic calcStep;
    logic unloadStep;
    logic [1:0] phase;
    logic lastItem;
    logic [1:0] twiddleIndex;
    logic [fftPkg::indexWidth-1:0] addrA;
    logic [fftPkg::indexWidth-1:0] addrB;
    fftPkg::sampleWord readData;

    fftAxiRegs axiRegs0 (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .startFwd, .startInv,
        .inPush, .inData, .inFull, .inCount,
        .outPop, .outData, .outEmpty, .outCount,
        .calculating, .done, .isInverse
    );

    sampleFifo #(.depth(fifoDepth)) inFifo (
        .clk, .rst,
        .push(inPush), .pushData(inData),
        .pop(loadStep), .popData(inPopData),
        .full(inFull), .empty(inEmpty), .count(inCount)
    );

    sampleFifo #(.depth(fifoDepth)) outFifo (
        .clk, .rst,
        .push(unloadStep), .pushData(readData.raw),
        .pop(outPop), .popData(outData),
        .full(outFull), .empty(outEmpty), .count(outCount)
    );

    fftControl control0 (
        .clk, .rst,
        .startFwd, .startInv, .inEmpty, .outFull, .lastItem,
        .calculating, .loadStep, .calcStep, .unloadStep, .isInverse, .done,
        .phase
    );

    fftSequencer sequencer0 (
        .clk, .rst,
        .phase, .loadStep, .calcStep, .unloadStep,
        .index(), .stage(), .twiddleIndex, .addrA, .addrB, .lastItem
    );

    fftDatapath datapath0 (
        .clk, .rst,
        .loadStep, .calcStep, .isInverse,
        .addrA, .addrB, .twiddleIndex,
        .loadData(inPopData), .readData
    );

endmodule

// ==== fftAsserts.sv ====
`timescale 1ns/1ps

module fftAsserts (
    input logic clk,
    input logic rst,
    input logic loadStep,
    input logic calcStep,
    input logic unloadStep,
    input logic outFull,
    input logic lastItem,
    input logic done
);

    logic [4:0] calcLen;

    // Length of the current run of calcStep
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            calcLen <= '0;
        end else if (calcStep) begin
            calcLen <= calcLen + 5'd1;
        end else begin
            calcLen <= '0;
        end
    end

    oneStrobe: assert property (@(posedge clk) disable iff (rst)
        $onehot0({loadStep, calcStep, unloadStep}))
        else $error("More than one step strobe active");

    calcTwelve: assert property (@(posedge clk) disable iff (rst)
        $fell(calcStep) |-> calcLen == 5'd12)
        else $error("CALC phase did not last 12 cycles");

    noUnloadWhenFull: assert property (@(posedge clk) disable iff (rst)
        !(unloadStep && outFull))
        else $error("unloadStep while the output FIFO is full");

    doneAfterUnload: assert property (@(posedge clk) disable iff (rst)
        (unloadStep && lastItem) |-> ##2 done)
        else $error("done did not follow the last unload step");

endmodule

// ==== fftTb.sv ====
`timescale 1ns/1ps

module fftTb;

    localparam int timeoutCycles = 64;
    localparam int timeoutPolls = 200;
    localparam logic [1:0] respOkay = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;
    // Forward twiddles in Q1.14
    localparam int twRe [4] = '{16384, 11585, 0, -11585};
    localparam int twIm [4] = '{0, -11585, -16384, -11585};

    logic clk;
    logic rst;
    logic [7:0] awaddr;
    logic awvalid;
    logic awready;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [7:0] araddr;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;

    logic [31:0] rngState;
    logic [31:0] frame [8];
    logic [31:0] expectQ [$];

    fftTop #(.fifoDepth(16)) dut0 (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    bind fftControl fftAsserts asserts0 (
        .clk(clk), .rst(rst),
        .loadStep(loadStep), .calcStep(calcStep), .unloadStep(unloadStep),
        .outFull(outFull), .lastItem(lastItem), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    task automatic failRun(input string why);
        $display("Finished with errors");
        $fatal(1, "%s", why);
    endtask

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] want);
        if (got !== want) begin
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, want);
            failRun({"wrong value for ", what});
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int bitReverse(input int i);
        return {i[0], i[1], i[2]};
    endfunction

    function automatic int halveTrunc(input int v);
        logic signed [15:0] h;
        h = 16'(v >>> 1);
        return int'(h);
    endfunction

    // Called and returns on a falling edge
    task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
        int waited;
        waited = 0;
        awaddr = addr;
        wdata = data;
        wstrb = 4'hF;
        awvalid = 1'b1;
        wvalid = 1'b1;
        bready = 1'b1;
        @(negedge clk);
        // Valids held a whole cycle with no response pending
        while (!bvalid) begin
            checkValue("awready with no write response pending", 32'(awready), 32'd1);
            checkValue("wready with no write response pending", 32'(wready), 32'd1);
            waited++;
            if (waited > timeoutCycles) failRun("AXI write got no response");
            @(negedge clk);
        end
        checkValue("awready with a write response pending", 32'(awready), 32'd0);
        checkValue("wready with a write response pending", 32'(wready), 32'd0);
        resp = bresp;
        awvalid = 1'b0;
        wvalid = 1'b0;
    endtask

    task automatic axiRead(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
        int waited;
        waited = 0;
        araddr = addr;
        arvalid = 1'b1;
        rready = 1'b1;
        @(negedge clk);
        while (!rvalid) begin
            checkValue("arready with no read response pending", 32'(arready), 32'd1);
            waited++;
            if (waited > timeoutCycles) failRun("AXI read got no response");
            @(negedge clk);
        end
        checkValue("arready with a read response pending", 32'(arready), 32'd0);
        data = rdata;
        resp = rresp;
        arvalid = 1'b0;
    endtask

    task automatic expectRead(input logic [7:0] addr, input logic [31:0] want,
                              input string what);
        logic [31:0] data;
        logic [1:0] resp;
        axiRead(addr, data, resp);
        checkValue({what, " response"}, 32'(resp), 32'(respOkay));
        checkValue(what, data, want);
    endtask

    // Bit-reversed load, three halving stages, results in natural order
    task automatic referenceFft(input logic inverse);
        int re [8];
        int im [8];
        int half;
        int offset;
        int a;
        int b;
        int w;
        int wr;
        int wi;
        int tr;
        int ti;
        int old;
        for (int i = 0; i < 8; i++) begin
            re[bitReverse(i)] = int'($signed(frame[i][31:16]));
            im[bitReverse(i)] = int'($signed(frame[i][15:0]));
        end
        for (int s = 0; s < 3; s++) begin
            half = 1 << s;
            for (int j = 0; j < 4; j++) begin
                offset = j % half;
                a = (j / half) * 2 * half + offset;
                b = a + half;
                w = (offset * 4) >> s;
                wr = twRe[w];
                wi = inverse ? -twIm[w] : twIm[w];
                tr = ((re[b] * wr) >>> 14) - ((im[b] * wi) >>> 14);
                ti = ((re[b] * wi) >>> 14) + ((im[b] * wr) >>> 14);
                old = re[a];
                re[a] = halveTrunc(old + tr);
                re[b] = halveTrunc(old - tr);
                old = im[a];
                im[a] = halveTrunc(old + ti);
                im[b] = halveTrunc(old - ti);
            end
        end
        for (int k = 0; k < 8; k++) begin
            expectQ.push_back({re[k][15:0], im[k][15:0]});
        end
    endtask

    task automatic pushFrame(input logic inverse);
        logic [1:0] resp;
        for (int i = 0; i < 8; i++) begin
            rngState = xorshift(rngState);
            frame[i] = rngState;
            axiWrite(fftPkg::regDataIn, frame[i], resp);
            checkValue("sample push response", 32'(resp), 32'(respOkay));
        end
        referenceFft(inverse);
    endtask

    task automatic startTransform(input logic inverse);
        logic [1:0] resp;
        axiWrite(fftPkg::regCtrl, inverse ? 32'h2 : 32'h1, resp);
        checkValue("start response", 32'(resp), 32'(respOkay));
    endtask

    task automatic waitDone();
        logic [31:0] status;
        logic [1:0] resp;
        int polls;
        polls = 0;
        axiRead(fftPkg::regStatus, status, resp);
        while (!status[1]) begin
            polls++;
            if (polls > timeoutPolls) failRun("transform never reported done");
            axiRead(fftPkg::regStatus, status, resp);
        end
    endtask

    task automatic waitInputDrained();
        logic [31:0] levels;
        logic [1:0] resp;
        int polls;
        polls = 0;
        axiRead(fftPkg::regLevels, levels, resp);
        while (levels[4:0] != 5'd0) begin
            polls++;
            if (polls > timeoutPolls) failRun("input FIFO was never drained");
            axiRead(fftPkg::regLevels, levels, resp);
        end
    endtask

    task automatic popResults(input int n);
        logic [31:0] data;
        logic [1:0] resp;
        for (int i = 0; i < n; i++) begin
            axiRead(fftPkg::regDataOut, data, resp);
            checkValue("result pop response", 32'(resp), 32'(respOkay));
            if (expectQ.size() == 0) failRun("more results than transforms started");
            checkValue("transform result", data, expectQ.pop_front());
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic resetAndStart();
        expectRead(fftPkg::regStatus, 32'h0, "status after reset");
        expectRead(fftPkg::regLevels, 32'h0, "levels after reset");
        // Start first so the FSM waits in LOAD for the samples
        startTransform(1'b0);
        expectRead(fftPkg::regStatus, 32'h1, "status waiting for samples");
        pushFrame(1'b0);
        waitDone();
        expectRead(fftPkg::regStatus, 32'h2, "status after done");
        popResults(8);
    endtask

    task automatic forwardTransform();
        pushFrame(1'b0);
        startTransform(1'b0);
        waitDone();
        expectRead(fftPkg::regStatus, 32'h2, "forward status");
        popResults(8);
        expectRead(fftPkg::regLevels, 32'h0, "levels after forward");
    endtask

    task automatic inverseTransform();
        pushFrame(1'b1);
        startTransform(1'b1);
        waitDone();
        expectRead(fftPkg::regStatus, 32'h6, "inverse status");
        popResults(8);
    endtask

    task automatic outputBackPressure();
        for (int f = 0; f < 2; f++) begin
            pushFrame(1'b0);
            startTransform(1'b0);
            waitDone();
        end
        expectRead(fftPkg::regLevels, 32'h0010_0000, "levels with full output");
        pushFrame(1'b1);
        startTransform(1'b1);
        waitInputDrained();
        for (int i = 0; i < 10; i++) begin
            expectRead(fftPkg::regStatus, 32'h5, "status while stalled");
        end
        expectRead(fftPkg::regLevels, 32'h0010_0000, "levels while stalled");
        popResults(16);
        waitDone();
        popResults(8);
    endtask

    task automatic errorResponses();
        logic [31:0] data;
        logic [1:0] resp;
        pushFrame(1'b0);
        pushFrame(1'b0);
        axiWrite(fftPkg::regDataIn, 32'h1234_5678, resp);
        checkValue("write to full input FIFO", 32'(resp), 32'(respSlvErr));
        expectRead(fftPkg::regLevels, 32'h0000_0010, "levels with full input");
        startTransform(1'b0);
        // Second start lands while busy
        startTransform(1'b0);
        waitDone();
        expectRead(fftPkg::regLevels, 32'h0008_0008, "levels after ignored start");
        popResults(8);
        startTransform(1'b0);
        waitDone();
        popResults(8);
        axiRead(fftPkg::regDataOut, data, resp);
        checkValue("read of empty output FIFO", 32'(resp), 32'(respSlvErr));
        expectRead(fftPkg::regLevels, 32'h0, "levels at the end");
    endtask

    initial begin
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        rngState = 32'h1d49f71f;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        resetAndStart();
        forwardTransform();
        inverseTransform();
        outputBackPressure();
        errorResponses();
        if (expectQ.size() == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            failRun("expected results were never read back");
        end
    end

endmodule

// ==== verilog.f ====
fftPkg.sv
fftAxiRegs.sv
sampleFifo.sv
fftControl.sv
fftSequencer.sv
fftDatapath.sv
fftTop.sv
fftAsserts.sv
fftTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module fftTb -o fftSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/fftSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi
exit 0
